// ==== project.f ====
eeprom_emu_pkg.sv
serial_input_sync.sv
eeprom_cmd_engine.sv
eeprom_dual_port_mem.sv
miso_shifter.sv
host_mem_port.sv
eeprom_emu_top.sv
tb_eeprom_emu.sv

// ==== tb_eeprom_emu.sv ====
`timescale 1ns/100ps

module tb_eeprom_emu;

    localparam int ADDR_W         = eeprom_emu_pkg::DEFAULT_ADDR_WIDTH;
    localparam int DEPTH          = 2**ADDR_W;
    localparam int DATA_FIRST     = 3 + ADDR_W;      // Sample index of data bit 7
    localparam int CMD_BITS       = DATA_FIRST + 8;  // One READ or WRITE command
    localparam int ACK_EDGES      = 4;               // Negedges from req drive to ack, no stall
    localparam int ACK_WAIT_LIMIT = 400;
    localparam int TIMEOUT_CYCLES = 60000;           // ~200 ops x 200 cycles plus margin

    logic                  sys_clk;
    logic                  reset;
    logic                  spi_clk, spi_mosi, spi_cs;
    wire                   spi_miso;
    logic                  host_req, host_we;
    logic [ADDR_W-1:0]     host_addr;
    eeprom_emu_pkg::byte_t host_wdata, host_rdata;
    logic                  host_ack, host_busy;

    // Reference model
    eeprom_emu_pkg::byte_t model_mem [DEPTH];
    logic                  model_valid [DEPTH];  // Byte written at least once
    logic                  model_we;             // Write-enable latch

    integer                seed;
    int                    err_count, check_count, tests_run, err_base, check_base;
    int                    cycle_count = 0;
    int                    i, edges, cut;
    logic [ADDR_W-1:0]     addr, addr2;
    eeprom_emu_pkg::byte_t data, data2, rd;
    logic [63:0]           miso;                 // MISO sample per rising edge
    logic                  busy_at_ack;

    eeprom_emu_top #(.ADDR_WIDTH(ADDR_W)) uut (
        .sys_clk(sys_clk), .reset(reset), .spi_clk(spi_clk), .spi_mosi(spi_mosi),
        .spi_cs(spi_cs), .spi_miso(spi_miso), .host_req(host_req), .host_we(host_we),
        .host_addr(host_addr), .host_wdata(host_wdata), .host_ack(host_ack),
        .host_rdata(host_rdata), .host_busy(host_busy)
    );

    initial begin
        sys_clk = 1'b0;
        forever #20 sys_clk = ~sys_clk;  // 40 ns period
    end

    // Watchdog
    always @(posedge sys_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout: run stopped after %0d clock cycles without finishing",
                     TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Command words and model
    //////////////////////////////////////////////////

    function automatic logic [63:0] read_cmd(input logic [ADDR_W-1:0] a);
        return {eeprom_emu_pkg::OP_READ, a, 8'h00};  // Data bits are don't care
    endfunction

    function automatic logic [63:0] write_cmd(input logic [ADDR_W-1:0] a,
                                              input eeprom_emu_pkg::byte_t d);
        return {eeprom_emu_pkg::OP_WRITE, a, d};
    endfunction

    function automatic logic [63:0] ewctl_cmd(input logic [1:0] arg);
        return {eeprom_emu_pkg::OP_EWCTL, arg};
    endfunction

    function automatic void model_serial_write(input logic [ADDR_W-1:0] a,
                                               input eeprom_emu_pkg::byte_t d);
        if (model_we) begin  // Protected part drops the data
            model_mem[a]   = d;
            model_valid[a] = 1'b1;
        end
    endfunction

    function automatic void model_host_write(input logic [ADDR_W-1:0] a,
                                             input eeprom_emu_pkg::byte_t d);
        model_mem[a]   = d;  // Host port ignores the latch
        model_valid[a] = 1'b1;
    endfunction

    //////////////////////////////////////////////////
    // Checks and reporting
    //////////////////////////////////////////////////

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("ERROR at %0t ns: %s (got %0h, expected %0h)", $time, what, actual,
                     expected);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("Test %0d %s finished: %0d checks, %0d errors", tests_run, name,
                 check_count - check_base, err_count - err_base);
        err_base   = err_count;
        check_base = check_count;
    endtask

    //////////////////////////////////////////////////
    // Serial master
    //////////////////////////////////////////////////

    // Bit-bang nbits of bits, MSB first, 4 cycles low then 4 high per bit
    task automatic serial_frame(input logic [63:0] bits, input int nbits,
                                output logic [63:0] samples);
        int k;
        samples = '0;
        @(posedge sys_clk);
        spi_cs <= 1'b1;
        for (k = 0; k < nbits; k++) begin
            spi_mosi <= bits[nbits-1-k];  // Change while clock low
            repeat (3) @(posedge sys_clk);
            @(negedge sys_clk);
            samples[k] = spi_miso;        // Just before the rising edge
            @(posedge sys_clk);
            spi_clk <= 1'b1;
            repeat (4) @(posedge sys_clk);
            spi_clk <= 1'b0;
        end
        repeat (4) @(posedge sys_clk);
        spi_cs   <= 1'b0;                 // End of frame
        spi_mosi <= 1'b0;
        repeat (4) @(posedge sys_clk);
        @(negedge sys_clk);
        check_equal(spi_miso, 1'bz, "MISO floats after frame");
    endtask

    task automatic check_floats(input logic [63:0] samples, input int first, input int count,
                                input string tag);
        int k;
        for (k = first; k < first + count; k++)
            check_equal(samples[k], 1'bz, $sformatf("%s, MISO before edge %0d", tag, k + 1));
    endtask

    // One READ command starting at sample index base
    task automatic check_serial_read(input logic [63:0] samples, input int base,
                                     input logic [ADDR_W-1:0] a, input string tag);
        int k;
        eeprom_emu_pkg::byte_t got;
        check_floats(samples, base, DATA_FIRST, tag);  // Opcode and address phase
        for (k = 0; k < 8; k++)
            got[7-k] = samples[base+DATA_FIRST+k];
        if (model_valid[a])
            check_equal(got, model_mem[a], $sformatf("%s, MISO byte at addr %0d", tag, a));
    endtask

    //////////////////////////////////////////////////
    // Host master, four-phase
    //////////////////////////////////////////////////

    task automatic host_access(input logic we, input logic [ADDR_W-1:0] a,
                               input eeprom_emu_pkg::byte_t d,
                               output eeprom_emu_pkg::byte_t rdata, output int n,
                               output logic busy_seen);
        @(posedge sys_clk);
        host_req   <= 1'b1;
        host_we    <= we;
        host_addr  <= a;
        host_wdata <= d;
        n = 0;
        do begin
            @(negedge sys_clk);
            n++;
        end while (!host_ack && n < ACK_WAIT_LIMIT);
        busy_seen = host_busy;
        rdata     = host_rdata;
        if (!host_ack) begin
            err_count++;
            $display("Host ack never arrived for address %0d at %0t ns", a, $time);
        end
        @(posedge sys_clk);
        host_req <= 1'b0;
        @(negedge sys_clk);
        check_equal(host_ack, 1'b1, "host_ack held while req high");
        @(negedge sys_clk);
        check_equal(host_ack, 1'b0, "host_ack drops after req falls");
    endtask

    task automatic host_write(input logic [ADDR_W-1:0] a, input eeprom_emu_pkg::byte_t d);
        eeprom_emu_pkg::byte_t unused;
        int n;
        logic b;
        host_access(1'b1, a, d, unused, n, b);
        check_equal(n, ACK_EDGES, "host write ack latency");
        model_host_write(a, d);
    endtask

    task automatic host_read(input logic [ADDR_W-1:0] a);
        eeprom_emu_pkg::byte_t got;
        int n;
        logic b;
        host_access(1'b0, a, 8'h00, got, n, b);
        check_equal(n, ACK_EDGES, "host read ack latency");
        if (model_valid[a])
            check_equal(got, model_mem[a], $sformatf("host read addr %0d", a));
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        reset      = 1'b1;
        spi_clk    = 1'b0;
        spi_mosi   = 1'b0;
        spi_cs     = 1'b0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        seed       = 32'heeb3_01b5;
        err_count  = 0;
        check_count = 0;
        tests_run  = 0;
        err_base   = 0;
        check_base = 0;
        for (i = 0; i < DEPTH; i++)
            model_valid[i] = 1'b0;  // Memory has no init file
        model_we = 1'b0;
        repeat (3) @(posedge sys_clk);
        reset <= 1'b0;

        // 1: fill every byte from the host, then random read back
        for (i = 0; i < DEPTH; i++)
            host_write(ADDR_W'(i), 8'($random(seed)));
        for (i = 0; i < 32; i++)
            host_read(ADDR_W'($random(seed)));
        end_test("host access");

        // 2: serial READ at random addresses
        for (i = 0; i < 16; i++) begin
            addr = ADDR_W'($random(seed));
            serial_frame(read_cmd(addr), CMD_BITS, miso);
            check_serial_read(miso, 0, addr, "serial read");
        end
        end_test("serial read");

        // 3: write-enable latch
        addr  = ADDR_W'($random(seed));
        data  = 8'($random(seed));
        data2 = ~data;                                     // Always differs
        host_write(addr, data);
        serial_frame(write_cmd(addr, data2), CMD_BITS, miso);  // Latch clear since reset
        check_floats(miso, 0, CMD_BITS, "write frame");
        model_serial_write(addr, data2);
        host_read(addr);
        serial_frame(ewctl_cmd(eeprom_emu_pkg::EW_ENABLE), 5, miso);
        model_we = 1'b1;
        serial_frame(write_cmd(addr, data2), CMD_BITS, miso);
        model_serial_write(addr, data2);
        host_read(addr);
        serial_frame(read_cmd(addr), CMD_BITS, miso);
        check_serial_read(miso, 0, addr, "read after enable");
        serial_frame(ewctl_cmd(eeprom_emu_pkg::EW_DISABLE), 5, miso);
        model_we = 1'b0;
        serial_frame(write_cmd(addr, data), CMD_BITS, miso);
        model_serial_write(addr, data);
        host_read(addr);
        serial_frame(read_cmd(addr), CMD_BITS, miso);
        check_serial_read(miso, 0, addr, "read after disable");
        end_test("write protection");

        // 4: aborted WRITE, then WRITE and READ in one frame
        serial_frame(ewctl_cmd(eeprom_emu_pkg::EW_ENABLE), 5, miso);
        model_we = 1'b1;
        addr = ADDR_W'($random(seed));
        data = 8'($random(seed));
        cut  = 4 + $unsigned($random(seed)) % (CMD_BITS - 4);  // CS drops before bit 18
        serial_frame(write_cmd(addr, data) >> (CMD_BITS - cut), cut, miso);
        host_read(addr);                                     // Model untouched
        addr2 = ADDR_W'($random(seed));
        data2 = 8'($random(seed));
        serial_frame((write_cmd(addr2, data2) << CMD_BITS) | read_cmd(addr2), 2 * CMD_BITS,
                     miso);
        model_serial_write(addr2, data2);
        check_floats(miso, 0, CMD_BITS, "first command of pair");
        check_serial_read(miso, CMD_BITS, addr2, "second command of pair");
        host_read(addr2);
        end_test("framing");

        // 5: host write during a serial WRITE frame
        addr  = ADDR_W'($random(seed));
        data  = 8'($random(seed));  // Serial value
        data2 = 8'($random(seed));  // Host value, lands last
        fork
            serial_frame(write_cmd(addr, data), CMD_BITS, miso);
            begin
                @(negedge sys_clk);
                while (!host_busy)
                    @(negedge sys_clk);
                host_access(1'b1, addr, data2, rd, edges, busy_at_ack);
            end
        join
        check_equal(edges > ACK_EDGES, 1'b1, "host write stalled behind serial write");
        check_equal(busy_at_ack, 1'b0, "no ack while host_busy high");
        check_equal(host_busy, 1'b0, "host_busy low after frame");
        model_serial_write(addr, data);
        model_host_write(addr, data2);
        host_read(addr);
        serial_frame(read_cmd(addr), CMD_BITS, miso);
        check_serial_read(miso, 0, addr, "read after collision");
        end_test("write collision");

        $display("%0d tests run, %0d checks, %0d errors", tests_run, check_count, err_count);
        if (err_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== eeprom_emu_top.sv ====
`timescale 1ns/100ps

module eeprom_emu_top #(
    parameter int ADDR_WIDTH = eeprom_emu_pkg::DEFAULT_ADDR_WIDTH
) (
    input  logic                  sys_clk,
    input  logic                  reset,
    // Serial pins
    input  logic                  spi_clk,
    input  logic                  spi_mosi,
    input  logic                  spi_cs,
    inout  wire                   spi_miso,
    // Host port
    input  logic                  host_req,
    input  logic                  host_we,
    input  logic [ADDR_WIDTH-1:0] host_addr,
    input  eeprom_emu_pkg::byte_t host_wdata,
    output logic                  host_ack,
    output eeprom_emu_pkg::byte_t host_rdata,
    output logic                  host_busy
);

    logic                  sclk_rise, cs_rise, cs_level, mosi_sync;
    logic                  mem_a_en, mem_a_we, mem_b_en, mem_b_we;
    logic [ADDR_WIDTH-1:0] mem_a_addr, mem_b_addr;
    eeprom_emu_pkg::byte_t mem_a_wdata, mem_a_rdata, mem_b_wdata, mem_b_rdata;
    logic                  load, shift, drop_oe, write_busy;
    eeprom_emu_pkg::byte_t load_data;

    assign host_busy = write_busy;  // Host sees serial write in progress

    serial_input_sync u_sync (
        .sys_clk(sys_clk), .reset(reset), .spi_clk(spi_clk), .spi_mosi(spi_mosi),
        .spi_cs(spi_cs), .sclk_rise(sclk_rise), .cs_rise(cs_rise),
        .cs_level(cs_level), .mosi_sync(mosi_sync)
    );

    eeprom_cmd_engine #(.ADDR_WIDTH(ADDR_WIDTH)) u_engine (
        .sys_clk(sys_clk), .reset(reset), .sclk_rise(sclk_rise), .cs_rise(cs_rise),
        .cs_level(cs_level), .mosi_sync(mosi_sync), .mem_a_en(mem_a_en),
        .mem_a_we(mem_a_we), .mem_a_addr(mem_a_addr), .mem_a_wdata(mem_a_wdata),
        .mem_a_rdata(mem_a_rdata), .load(load), .load_data(load_data), .shift(shift),
        .drop_oe(drop_oe), .write_busy(write_busy)
    );

    eeprom_dual_port_mem #(.ADDR_WIDTH(ADDR_WIDTH)) u_mem (
        .sys_clk(sys_clk),
        .mem_a_en(mem_a_en), .mem_a_we(mem_a_we), .mem_a_addr(mem_a_addr),
        .mem_a_wdata(mem_a_wdata), .mem_a_rdata(mem_a_rdata),
        .mem_b_en(mem_b_en), .mem_b_we(mem_b_we), .mem_b_addr(mem_b_addr),
        .mem_b_wdata(mem_b_wdata), .mem_b_rdata(mem_b_rdata)
    );

    miso_shifter u_miso (
        .sys_clk(sys_clk), .reset(reset), .load(load), .load_data(load_data),
        .shift(shift), .drop_oe(drop_oe), .spi_miso(spi_miso)
    );

    host_mem_port #(.ADDR_WIDTH(ADDR_WIDTH)) u_host (
        .sys_clk(sys_clk), .reset(reset), .host_req(host_req), .host_we(host_we),
        .host_addr(host_addr), .host_wdata(host_wdata), .write_busy(write_busy),
        .host_ack(host_ack), .host_rdata(host_rdata), .mem_b_en(mem_b_en),
        .mem_b_we(mem_b_we), .mem_b_addr(mem_b_addr), .mem_b_wdata(mem_b_wdata),
        .mem_b_rdata(mem_b_rdata)
    );

endmodule

// ==== host_mem_port.sv ====
`timescale 1ns/100ps

module host_mem_port #(
    parameter int ADDR_WIDTH = eeprom_emu_pkg::DEFAULT_ADDR_WIDTH
) (
    input  logic                  sys_clk,
    input  logic                  reset,
    input  logic                  host_req,
    input  logic                  host_we,
    input  logic [ADDR_WIDTH-1:0] host_addr,
    input  eeprom_emu_pkg::byte_t host_wdata,
    input  logic                  write_busy,
    output logic                  host_ack,
    output eeprom_emu_pkg::byte_t host_rdata,
    output logic                  mem_b_en,
    output logic                  mem_b_we,
    output logic [ADDR_WIDTH-1:0] mem_b_addr,
    output eeprom_emu_pkg::byte_t mem_b_wdata,
    input  eeprom_emu_pkg::byte_t mem_b_rdata
);

    typedef enum logic [1:0] {
        hs_wait,     // Idle, watching host_req
        hs_access,   // Port B strobe out
        hs_ack,      // Read data back, raise ack
        hs_release   // Hold ack until req drops
    } hs_state_t;

    hs_state_t state;

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            state    <= hs_wait;
            host_ack <= 1'b0;
            mem_b_en <= 1'b0;
            mem_b_we <= 1'b0;
        end else begin
            case (state)
                hs_wait: begin
                    // Writes hold off while a serial WRITE frame runs
                    if (host_req && !(host_we && write_busy)) begin
                        mem_b_en    <= 1'b1;
                        mem_b_we    <= host_we;
                        mem_b_addr  <= host_addr;
                        mem_b_wdata <= host_wdata;
                        state       <= hs_access;
                    end
                end
                hs_access: begin
                    mem_b_en <= 1'b0;  // Single access
                    state    <= hs_ack;
                end
                hs_ack: begin
                    if (!mem_b_we)
                        host_rdata <= mem_b_rdata;  // Keep old value on writes
                    host_ack <= 1'b1;
                    state    <= hs_release;
                end
                hs_release: begin
                    if (!host_req) begin
                        host_ack <= 1'b0;
                        state    <= hs_wait;
                    end
                end
                default: state <= hs_wait;
            endcase
        end
    end

    // Four-phase rule, ack only answers a live request
    a_ack_needs_req: assert property (@(posedge sys_clk) disable iff (reset)
        $rose(host_ack) |-> host_req);

endmodule

// ==== miso_shifter.sv ====
`timescale 1ns/100ps

module miso_shifter (
    input  logic                  sys_clk,
    input  logic                  reset,
    input  logic                  load,
    input  eeprom_emu_pkg::byte_t load_data,
    input  logic                  shift,
    input  logic                  drop_oe,
    inout  wire                   spi_miso
);

    eeprom_emu_pkg::byte_t out_reg;  // MSB is on the pin
    logic                  spi_oe;

    //////////////////////////////////////////////////
    // Output enable
    //////////////////////////////////////////////////

    always_ff @(posedge sys_clk) begin
        if (reset)
            spi_oe <= 1'b0;
        else if (drop_oe)
            spi_oe <= 1'b0;  // Frame abort beats a late load
        else if (load)
            spi_oe <= 1'b1;
    end

    //////////////////////////////////////////////////
    // Data shift register
    //////////////////////////////////////////////////

    always_ff @(posedge sys_clk) begin
        if (load)
            out_reg <= load_data;
        else if (shift)
            out_reg <= {out_reg[6:0], 1'b0};  // MSB first
    end

    assign spi_miso = spi_oe ? out_reg[7] : 1'bz;  // Pin floats when idle

    // Load comes from the engine, shift from the edge detector
    a_no_shift_on_load: assert property (@(posedge sys_clk) disable iff (reset)
        !(load && shift));

endmodule

// ==== eeprom_dual_port_mem.sv ====
`timescale 1ns/100ps

module eeprom_dual_port_mem #(
    parameter int ADDR_WIDTH = eeprom_emu_pkg::DEFAULT_ADDR_WIDTH
) (
    input  logic                  sys_clk,
    // Port A, serial engine
    input  logic                  mem_a_en,
    input  logic                  mem_a_we,
    input  logic [ADDR_WIDTH-1:0] mem_a_addr,
    input  eeprom_emu_pkg::byte_t mem_a_wdata,
    output eeprom_emu_pkg::byte_t mem_a_rdata,
    // Port B, host side
    input  logic                  mem_b_en,
    input  logic                  mem_b_we,
    input  logic [ADDR_WIDTH-1:0] mem_b_addr,
    input  eeprom_emu_pkg::byte_t mem_b_wdata,
    output eeprom_emu_pkg::byte_t mem_b_rdata
);

    // Contents undefined until written
    eeprom_emu_pkg::byte_t mem [2**ADDR_WIDTH];

    // Both ports in one block, read returns old data on a write
    always_ff @(posedge sys_clk) begin
        if (mem_a_en) begin
            mem_a_rdata <= mem[mem_a_addr];
            if (mem_a_we)
                mem[mem_a_addr] <= mem_a_wdata;
        end
        if (mem_b_en) begin
            mem_b_rdata <= mem[mem_b_addr];
            if (mem_b_we)
                mem[mem_b_addr] <= mem_b_wdata;  // Port B wins a same-cycle clash
        end
    end

endmodule

// ==== eeprom_cmd_engine.sv ====
`timescale 1ns/100ps

module eeprom_cmd_engine #(
    parameter int ADDR_WIDTH = eeprom_emu_pkg::DEFAULT_ADDR_WIDTH
) (
    input  logic                   sys_clk,
    input  logic                   reset,
    input  logic                   sclk_rise,
    input  logic                   cs_rise,
    input  logic                   cs_level,
    input  logic                   mosi_sync,
    output logic                   mem_a_en,
    output logic                   mem_a_we,
    output logic [ADDR_WIDTH-1:0]  mem_a_addr,
    output eeprom_emu_pkg::byte_t  mem_a_wdata,
    input  eeprom_emu_pkg::byte_t  mem_a_rdata,
    output logic                   load,
    output eeprom_emu_pkg::byte_t  load_data,
    output logic                   shift,
    output logic                   drop_oe,
    output logic                   write_busy
);

    typedef enum logic [2:0] {
        st_idle,     // Chip not selected
        st_opcode,   // Collecting 3 opcode bits
        st_address,  // Collecting address bits
        st_data,     // READ out or WRITE in, 8 bits
        st_control,  // Two write-control bits
        st_done      // Command finished, rearm decode
    } state_t;

    state_t                state;
    logic [2:0]            bit_cnt;      // Bits taken in current field
    eeprom_emu_pkg::byte_t shift_in;     // MOSI history
    eeprom_emu_pkg::byte_t byte_now;     // History including current bit
    logic [2:0]            cmd_op;       // Opcode of running command
    logic                  we_latch;     // Write-enable latch
    logic                  read_pend;    // Port A read data arrives now
    logic                  last_addr_bit;
    logic                  last_data_bit;

    //////////////////////////////////////////////////
    // Combinational helpers and shifter control
    //////////////////////////////////////////////////

    assign byte_now      = {shift_in[6:0], mosi_sync};
    assign last_addr_bit = sclk_rise && (bit_cnt == 3'(ADDR_WIDTH - 1));
    assign last_data_bit = sclk_rise && (bit_cnt == 3'd7);

    assign shift     = sclk_rise;                     // MISO advances on every edge
    assign load      = read_pend && (state == st_data);  // Aborted reads never load
    assign load_data = mem_a_rdata;

    // Release MISO after bit 18, or when the frame dies
    assign drop_oe = ((state == st_data) && (cmd_op == eeprom_emu_pkg::OP_READ) &&
                      last_data_bit) || ((state != st_idle) && !cs_level);

    //////////////////////////////////////////////////
    // Frame FSM
    //////////////////////////////////////////////////

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            state      <= st_idle;
            bit_cnt    <= '0;
            cmd_op     <= '0;
            we_latch   <= 1'b0;  // Writes locked after reset
            write_busy <= 1'b0;
            mem_a_en   <= 1'b0;
            mem_a_we   <= 1'b0;
            read_pend  <= 1'b0;
        end else begin
            mem_a_en  <= 1'b0;  // Port A strobes last one cycle
            mem_a_we  <= 1'b0;
            read_pend <= mem_a_en && !mem_a_we;  // Memory has one cycle latency
            if (sclk_rise) begin
                shift_in <= byte_now;
                bit_cnt  <= bit_cnt + 3'd1;
            end
            if ((state != st_idle) && !cs_level) begin
                // CS low ends the frame, half-done command is lost
                state      <= st_idle;
                write_busy <= 1'b0;
            end else begin
                case (state)
                    st_idle: begin
                        if (cs_rise) begin
                            state   <= st_opcode;
                            bit_cnt <= '0;
                        end
                    end
                    st_opcode: begin
                        if (sclk_rise && (bit_cnt == 3'd2)) begin
                            bit_cnt <= '0;
                            cmd_op  <= byte_now[2:0];
                            case (byte_now[2:0])
                                eeprom_emu_pkg::OP_READ:  state <= st_address;
                                eeprom_emu_pkg::OP_WRITE: begin
                                    state      <= st_address;
                                    write_busy <= 1'b1;  // Stall host writes
                                end
                                eeprom_emu_pkg::OP_EWCTL: state <= st_control;
                                default:                  state <= st_done;  // Unknown, retry
                            endcase
                        end
                    end
                    st_address: begin
                        if (last_addr_bit) begin
                            bit_cnt    <= '0;
                            mem_a_addr <= byte_now[ADDR_WIDTH-1:0];
                            state      <= st_data;
                            if (cmd_op == eeprom_emu_pkg::OP_READ)
                                mem_a_en <= 1'b1;  // Fetch byte for MISO
                        end
                    end
                    st_data: begin
                        if (last_data_bit) begin
                            state <= st_done;
                            if (cmd_op == eeprom_emu_pkg::OP_WRITE) begin
                                write_busy <= 1'b0;
                                if (we_latch) begin  // Protected part ignores the data
                                    mem_a_en    <= 1'b1;
                                    mem_a_we    <= 1'b1;
                                    mem_a_wdata <= byte_now;
                                end
                            end
                        end
                    end
                    st_control: begin
                        if (sclk_rise && (bit_cnt == 3'd1)) begin
                            state <= st_done;
                            if (byte_now[1:0] == eeprom_emu_pkg::EW_ENABLE)
                                we_latch <= 1'b1;
                            else if (byte_now[1:0] == eeprom_emu_pkg::EW_DISABLE)
                                we_latch <= 1'b0;
                        end
                    end
                    st_done: begin
                        bit_cnt <= '0;  // CS still high, next command follows
                        state   <= st_opcode;
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Serial write reaches memory only when the latch was set at issue time
    a_write_needs_latch: assert property (@(posedge sys_clk) disable iff (reset)
        (mem_a_en && mem_a_we) |-> $past(we_latch));

    // MISO load comes two cycles after the last address bit of a READ
    a_load_in_read: assert property (@(posedge sys_clk) disable iff (reset)
        load |-> ((cmd_op == eeprom_emu_pkg::OP_READ) && $past(last_addr_bit, 2)));

endmodule

// ==== serial_input_sync.sv ====
`timescale 1ns/100ps

module serial_input_sync (
    input  logic sys_clk,
    input  logic reset,
    input  logic spi_clk,
    input  logic spi_mosi,
    input  logic spi_cs,
    output logic sclk_rise,
    output logic cs_rise,
    output logic cs_level,
    output logic mosi_sync
);

    //////////////////////////////////////////////////
    // Pin synchronisers
    //////////////////////////////////////////////////

    // Bit order in the vectors: [2] cs, [1] sclk, [0] mosi
    logic [2:0] pins_s1;  // First stage, may go metastable
    logic [2:0] pins_s2;  // Second stage, safe to use
    logic [2:1] pins_s3;  // Extra stage for edge detect

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            pins_s1 <= '0;
            pins_s2 <= '0;
            pins_s3 <= '0;
        end else begin
            pins_s1 <= {spi_cs, spi_clk, spi_mosi};
            pins_s2 <= pins_s1;
            pins_s3 <= pins_s2[2:1];  // Previous level of cs and sclk
        end
    end

    //////////////////////////////////////////////////
    // Edge pulses and levels
    //////////////////////////////////////////////////

    // Pulses line up with mosi_sync, two cycles after the pin edge
    assign sclk_rise = pins_s2[1] & ~pins_s3[1];
    assign cs_rise   = pins_s2[2] & ~pins_s3[2];
    assign cs_level  = pins_s2[2];
    assign mosi_sync = pins_s2[0];

endmodule

// ==== eeprom_emu_pkg.sv ====
package eeprom_emu_pkg;

    //////////////////////////////////////////////////
    // Data and geometry
    //////////////////////////////////////////////////

    // One stored byte, 8-bit organisation only
    typedef logic [7:0] byte_t;

    localparam int DEFAULT_ADDR_WIDTH = 7;  // 128 bytes

    //////////////////////////////////////////////////
    // Serial command set, 93C46 style
    //////////////////////////////////////////////////

    // Start bit plus two opcode bits, sent MSB first
    localparam logic [2:0] OP_READ  = 3'b110;  // Read one byte
    localparam logic [2:0] OP_WRITE = 3'b101;  // Write one byte
    localparam logic [2:0] OP_EWCTL = 3'b100;  // Write-enable control

    // Two argument bits that follow OP_EWCTL
    localparam logic [1:0] EW_ENABLE  = 2'b11;  // Set write-enable latch
    localparam logic [1:0] EW_DISABLE = 2'b00;  // Clear it

    // Frame layout for the default width:
    //   bits 1..3   opcode
    //   bits 4..10  address
    //   bits 11..18 data (driven on MISO for READ)
    // Control frames carry their argument on bits 4..5

endpackage
